/* branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvDecode_settings.svh"

module branchUnit (
	input  logic                  branch,
	input  logic                  jump,
	input  logic                  isJalr,
	input  rvIsaPkg::branchCond   funct3,
	input  logic [`RV_XLEN-1:0]   pc,
	input  logic [`RV_XLEN-1:0]   immediate,
	input  rvPipePkg::fwdOperands fwd,
	output rvPipePkg::redirect    redir
);

	import rvIsaPkg::*;

	logic                condMet;
	logic [`RV_XLEN-1:0] pcTarget;
	logic [`RV_XLEN-1:0] regTarget;

	// Compare on operands already forwarded
	always_comb begin
		case (funct3)
			BR_EQ:  condMet = (fwd.srcA == fwd.srcB);
			BR_NE:  condMet = (fwd.srcA != fwd.srcB);
			BR_LT:  condMet = ($signed(fwd.srcA) < $signed(fwd.srcB));
			BR_GE:  condMet = ($signed(fwd.srcA) >= $signed(fwd.srcB));
			BR_LTU: condMet = (fwd.srcA < fwd.srcB);
			BR_GEU: condMet = (fwd.srcA >= fwd.srcB);
			// Reserved funct3 values never branch
			default: condMet = 1'b0;
		endcase
	end

	// Branches and JAL are PC relative
	assign pcTarget = pc + immediate;

	// JALR target has bit 0 cleared
	assign regTarget = (fwd.srcA + immediate) & ~`RV_XLEN'(1);

	assign redir.target = isJalr ? regTarget : pcTarget;

	// Jumps always redirect
	assign redir.take = jump || (branch && condMet);

	// A redirect must come from a decoded control transfer
	always_comb begin
		assert (!redir.take || branch || jump)
			else $error("branchUnit: redirect without branch or jump");
	end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvDecode_settings.svh"

module controlUnit (
	input  logic [`RV_XLEN-1:0] instr,
	output rvPipePkg::idexCtrl  ctrl,
	output rvIsaPkg::immFormat  immType,
	output logic                branch,
	output logic                jump,
	output logic                isJalr
);

	import rvIsaPkg::*;

	opcodeKind              opcode;
	logic [`RV_F3_BITS-1:0] funct3;
	// funct7 bit 5 selects SUB and SRA
	logic                   altOp;

	assign opcode = opcodeKind'(instr[`RV_OPC_BITS-1:0]);
	assign funct3 = instr[14:12];
	assign altOp  = instr[30];

	// ALU operation from funct3
	// alt picks SUB on 000 and SRA on 101
	function automatic aluOp aluFromFunct3(input logic [2:0] f3, input logic alt);
		aluOp op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		// Bubble unless a known opcode says otherwise
		ctrl    = '0;
		immType = IMM_NONE;
		branch  = 1'b0;
		jump    = 1'b0;
		isJalr  = 1'b0;
		case (opcode)
			OPC_LUI: begin
				// Result is the U immediate itself
				ctrl.immSel         = 1'b1;
				ctrl.setDataZero    = 1'b1;
				ctrl.aluOp          = ALU_PASSB;
				ctrl.regWriteEnable = 1'b1;
				immType             = IMM_U;
			end
			OPC_AUIPC: begin
				ctrl.immSel         = 1'b1;
				ctrl.pcOperand      = 1'b1;
				ctrl.regWriteEnable = 1'b1;
				immType             = IMM_U;
			end
			OPC_JAL: begin
				// Execute writes pc+4 to rd
				ctrl.pcOperand      = 1'b1;
				ctrl.addConstant4   = 1'b1;
				ctrl.regWriteEnable = 1'b1;
				immType             = IMM_J;
				jump                = 1'b1;
			end
			OPC_JALR: begin
				ctrl.pcOperand      = 1'b1;
				ctrl.addConstant4   = 1'b1;
				ctrl.regWriteEnable = 1'b1;
				immType             = IMM_I;
				jump                = 1'b1;
				isJalr              = 1'b1;
			end
			OPC_BRANCH: begin
				// Resolved here, nothing left for execute
				immType = IMM_B;
				branch  = 1'b1;
			end
			OPC_LOAD: begin
				// Address is rs1 plus offset
				ctrl.immSel         = 1'b1;
				ctrl.memRead        = 1'b1;
				ctrl.memType        = funct3;
				ctrl.regWriteEnable = 1'b1;
				immType             = IMM_I;
			end
			OPC_STORE: begin
				ctrl.immSel   = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memType  = funct3;
				immType       = IMM_S;
			end
			OPC_OPIMM: begin
				// No SUB with an immediate, only SRA uses bit 30
				ctrl.immSel         = 1'b1;
				ctrl.aluOp          = aluFromFunct3(funct3, altOp && funct3 == 3'b101);
				ctrl.regWriteEnable = 1'b1;
				immType             = IMM_I;
			end
			OPC_OP: begin
				ctrl.aluOp          = aluFromFunct3(funct3, altOp);
				ctrl.regWriteEnable = 1'b1;
			end
			default: begin
				// FENCE, SYSTEM and unknown opcodes stay a bubble
			end
		endcase
	end

	// Never a load and a store at once
	always_comb begin
		assert (!(ctrl.memRead && ctrl.memWrite))
			else $error("controlUnit: memRead and memWrite both set");
	end

endmodule

`default_nettype wire

/* immExtender.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvDecode_settings.svh"

module immExtender (
	input  logic [`RV_XLEN-1:0] instr,
	input  rvIsaPkg::immFormat  immType,
	output logic [`RV_XLEN-1:0] immediate
);

	import rvIsaPkg::*;

	// Sign source for every format
	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (immType)
			// Loads, OP-IMM, JALR
			IMM_I: immediate = {{20{sign}}, instr[31:20]};
			// Store offset split around rd field
			IMM_S: immediate = {{20{sign}}, instr[31:25], instr[11:7]};
			// Branch offset, always even
			IMM_B: immediate = {{19{sign}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			// Upper twenty bits, low twelve zero
			IMM_U: immediate = {instr[31:12], 12'b0};
			// JAL offset, always even
			IMM_J: immediate = {{11{sign}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: immediate = '0;
		endcase
	end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvDecode_settings.svh"

module regFile (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`RV_REG_BITS-1:0] rs1,
	input  logic [`RV_REG_BITS-1:0] rs2,
	input  rvPipePkg::wbBundle      wb,
	output logic [`RV_XLEN-1:0]     rd1,
	output logic [`RV_XLEN-1:0]     rd2
);

	logic [`RV_XLEN-1:0] regs [`RV_REGS];
	// Write qualified by a nonzero destination
	logic                wbLive;
	logic                hit1;
	logic                hit2;

	assign wbLive = wb.writeEnable && (wb.rd != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wbLive) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Same-cycle write seen by the reader
	assign hit1 = wbLive && (wb.rd == rs1);
	assign hit2 = wbLive && (wb.rd == rs2);

	// x0 reads zero regardless of storage
	assign rd1 = (rs1 == '0) ? '0 : (hit1 ? wb.data : regs[rs1]);
	assign rd2 = (rs2 == '0) ? '0 : (hit2 ? wb.data : regs[rs2]);

	xZeroHeld: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("regFile: x0 storage not zero");

endmodule

`default_nettype wire

/* runSim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tbRvDecode -f rvDecode.f -o simRvDecode \
	&& ./obj_dir/simRvDecode > sim.log 2>&1 \
	|| echo "Build or simulation step failed"

[ -f sim.log ] && cat sim.log
grep -qx "Done: no errors" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* rvDecode.f */
+incdir+.
rvIsaPkg.sv
rvPipePkg.sv
controlUnit.sv
immExtender.sv
regFile.sv
branchUnit.sv
rvDecode.sv
tbRvDecode.sv

/* rvDecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvDecode_settings.svh"

module rvDecode (
	input  logic                  clk,
	input  logic                  reset,
	input  rvPipePkg::ifidBundle  ifid,
	input  rvPipePkg::wbBundle    wb,
	input  rvPipePkg::fwdOperands fwd,
	output rvPipePkg::idexBundle  idex,
	output rvPipePkg::redirect    redir
);

	import rvIsaPkg::*;

	// Decoder to extender and branch unit
	immFormat immType;
	logic     branch;
	logic     jump;
	logic     isJalr;

	controlUnit iControlUnit (
		.instr   (ifid.instr),
		.ctrl    (idex.ctrl),
		.immType (immType),
		.branch  (branch),
		.jump    (jump),
		.isJalr  (isJalr)
	);

	immExtender iImmExtender (
		.instr     (ifid.instr),
		.immType   (immType),
		.immediate (idex.immediate)
	);

	// Reads from the decoding instruction, writes from MEM/WB
	regFile iRegFile (
		.clk   (clk),
		.reset (reset),
		.rs1   (ifid.instr[19:15]),
		.rs2   (ifid.instr[24:20]),
		.wb    (wb),
		.rd1   (idex.regData1),
		.rd2   (idex.regData2)
	);

	branchUnit iBranchUnit (
		.branch    (branch),
		.jump      (jump),
		.isJalr    (isJalr),
		.funct3    (branchCond'(ifid.instr[14:12])),
		.pc        (ifid.pc),
		.immediate (idex.immediate),
		.fwd       (fwd),
		.redir     (redir)
	);

endmodule

`default_nettype wire

/* rvDecode_settings.svh */
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Data path and PC width of the core
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REGS 32

// Register address width
// Must stay log2 of RV_REGS
`define RV_REG_BITS 5

// Major opcode field width, instr[6:0]
`define RV_OPC_BITS 7

// Width of funct3, shared by ALU, branch and memory size decode
`define RV_F3_BITS 3

`endif

/* rvIsaPkg.sv */
package rvIsaPkg;

	// RV32I major opcodes, instr[6:0]
	// Anything outside this list decodes to a bubble
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcodeKind;

	// Immediate layouts
	// NONE for R-type and bubbles, yields zero
	typedef enum logic [2:0] {
		IMM_NONE = 3'd0,
		IMM_I    = 3'd1,
		IMM_S    = 3'd2,
		IMM_B    = 3'd3,
		IMM_U    = 3'd4,
		IMM_J    = 3'd5
	} immFormat;

	// Execute stage operations
	// ADD is zero so a cleared control word still means add
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_SLL   = 4'd2,
		ALU_SLT   = 4'd3,
		ALU_SLTU  = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_AND   = 4'd9,
		ALU_PASSB = 4'd10
	} aluOp;

	// Branch conditions, encoded exactly as funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branchCond;

endpackage

/* rvPipePkg.sv */
`include "rvDecode_settings.svh"

package rvPipePkg;

	// IF/ID register contents
	typedef struct packed {
		logic [`RV_XLEN-1:0] instr;
		logic [`RV_XLEN-1:0] pc;
		logic [`RV_XLEN-1:0] pcPlus4;
	} ifidBundle;

	// Write back from MEM/WB
	typedef struct packed {
		logic                    writeEnable;
		logic [`RV_REG_BITS-1:0] rd;
		logic [`RV_XLEN-1:0]     data;
	} wbBundle;

	// Operands after the external forwarding muxes
	typedef struct packed {
		logic [`RV_XLEN-1:0] srcA;
		logic [`RV_XLEN-1:0] srcB;
	} fwdOperands;

	// Execute, memory and writeback control
	// All zero is a bubble
	typedef struct packed {
		// ALU B operand is the immediate
		logic           immSel;
		// ALU A operand is the PC
		logic           pcOperand;
		// ALU A operand forced to zero
		logic           setDataZero;
		rvIsaPkg::aluOp aluOp;
		logic           memRead;
		// funct3 of the load or store, size and sign
		logic [2:0]     memType;
		logic           memWrite;
		// ALU B operand is 4, for link address
		logic           addConstant4;
		logic           regWriteEnable;
	} idexCtrl;

	// ID/EX register contents
	typedef struct packed {
		logic [`RV_XLEN-1:0] regData1;
		logic [`RV_XLEN-1:0] regData2;
		logic [`RV_XLEN-1:0] immediate;
		idexCtrl             ctrl;
	} idexBundle;

	// Fetch redirect from decode
	typedef struct packed {
		logic                take;
		logic [`RV_XLEN-1:0] target;
	} redirect;

endpackage

/* tbRvDecode.sv */
`timescale 1ns/1ps
`include "rvDecode_settings.svh"

module tbRvDecode;

	import rvIsaPkg::*;
	import rvPipePkg::*;

	// Vectors per test
	localparam int resetCycles = 16;
	localparam int x0Writes = 10;
	localparam int regWrites = 40;
	localparam int immPerFmt = 16;
	localparam int ctrlPerOp = 16;
	localparam int unknownOps = 16;
	localparam int brRandom = 10;
	localparam int jumpsPerKind = 20;
	// Cycles spent by all tests together
	localparam int testCycles = `RV_REGS + 2 * x0Writes + 2 * regWrites + 6 * immPerFmt
		+ 9 * ctrlPerOp + unknownOps + 2 + 6 * (4 + brRandom) + 2 * jumpsPerKind;
	localparam int cycleLimit = 2 * (resetCycles + testCycles);

	localparam logic [6:0] knownOps [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
		OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP};
	// One opcode per immediate format, I twice
	localparam logic [6:0] immOps [6] = '{OPC_LOAD, OPC_OPIMM, OPC_STORE, OPC_BRANCH,
		OPC_LUI, OPC_JAL};

	logic        clk;
	logic        reset;
	ifidBundle   ifid;
	wbBundle     wb;
	fwdOperands  fwd;
	idexBundle   idex;
	redirect     redir;
	int          errors;
	int          vectors;
	int          cycles = 0;
	int unsigned seedInit;

	rvDecode i_rvDecode (
		.clk   (clk),
		.reset (reset),
		.ifid  (ifid),
		.wb    (wb),
		.fwd   (fwd),
		.idex  (idex),
		.redir (redir)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reference model

	// Immediate as laid out in the ISA manual
	function automatic logic [31:0] refImm(input logic [31:0] in);
		case (in[6:0])
			OPC_LOAD, OPC_OPIMM, OPC_JALR: return {{21{in[31]}}, in[30:20]};
			OPC_STORE: return {{21{in[31]}}, in[30:25], in[11:7]};
			OPC_BRANCH: return {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC: return {in[31:12], 12'h000};
			OPC_JAL: return {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
			default: return 32'h0;
		endcase
	endfunction

	function automatic aluOp refAlu(input logic [2:0] f3, input logic alt);
		aluOp op;
		if (f3 == 3'b000) begin
			op = alt ? ALU_SUB : ALU_ADD;
		end else if (f3 == 3'b001) begin
			op = ALU_SLL;
		end else if (f3 == 3'b010) begin
			op = ALU_SLT;
		end else if (f3 == 3'b011) begin
			op = ALU_SLTU;
		end else if (f3 == 3'b100) begin
			op = ALU_XOR;
		end else if (f3 == 3'b101) begin
			op = alt ? ALU_SRA : ALU_SRL;
		end else if (f3 == 3'b110) begin
			op = ALU_OR;
		end else begin
			op = ALU_AND;
		end
		return op;
	endfunction

	function automatic idexCtrl refCtrl(input logic [31:0] in);
		idexCtrl c;
		c = '0;
		case (in[6:0])
			OPC_LUI: begin
				c.immSel = 1'b1;
				c.setDataZero = 1'b1;
				c.aluOp = ALU_PASSB;
				c.regWriteEnable = 1'b1;
			end
			OPC_AUIPC: begin
				c.immSel = 1'b1;
				c.pcOperand = 1'b1;
				c.regWriteEnable = 1'b1;
			end
			OPC_JAL, OPC_JALR: begin
				// Link value pc+4
				c.pcOperand = 1'b1;
				c.addConstant4 = 1'b1;
				c.regWriteEnable = 1'b1;
			end
			OPC_LOAD: begin
				c.immSel = 1'b1;
				c.memRead = 1'b1;
				c.memType = in[14:12];
				c.regWriteEnable = 1'b1;
			end
			OPC_STORE: begin
				c.immSel = 1'b1;
				c.memWrite = 1'b1;
				c.memType = in[14:12];
			end
			OPC_OPIMM: begin
				// Bit 30 only matters for SRAI
				c.immSel = 1'b1;
				c.aluOp = refAlu(in[14:12], in[30] && in[14:12] == 3'b101);
				c.regWriteEnable = 1'b1;
			end
			OPC_OP: begin
				c.aluOp = refAlu(in[14:12], in[30]);
				c.regWriteEnable = 1'b1;
			end
			default: c = '0;
		endcase
		return c;
	endfunction

	function automatic redirect refRedir(input logic [31:0] in, input logic [31:0] pc,
		input logic [31:0] imm, input logic [31:0] a, input logic [31:0] b);
		redirect r;
		logic [31:0] sum;
		r.take = 1'b0;
		r.target = pc + imm;
		sum = a + imm;
		case (in[6:0])
			OPC_BRANCH: begin
				case (in[14:12])
					3'b000: r.take = (a == b);
					3'b001: r.take = (a != b);
					3'b100: r.take = ($signed(a) < $signed(b));
					3'b101: r.take = ($signed(a) >= $signed(b));
					3'b110: r.take = (a < b);
					3'b111: r.take = (a >= b);
					default: r.take = 1'b0;
				endcase
			end
			OPC_JAL: r.take = 1'b1;
			OPC_JALR: begin
				r.take = 1'b1;
				r.target = {sum[31:1], 1'b0};
			end
			default: r.take = 1'b0;
		endcase
		return r;
	endfunction

	// Shadow of the architectural registers
	logic [`RV_XLEN-1:0]     shadow [`RV_REGS];
	logic [`RV_REG_BITS-1:0] rs1Field;
	logic [`RV_REG_BITS-1:0] rs2Field;
	logic                    wbLive;
	logic [`RV_XLEN-1:0]     expImm;
	logic [`RV_XLEN-1:0]     expRd1;
	logic [`RV_XLEN-1:0]     expRd2;
	idexCtrl                 expCtrl;
	redirect                 expRedir;
	logic                    expXfer;

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_REGS; i++) begin
				shadow[i] <= '0;
			end
		end else if (wb.writeEnable && wb.rd != '0) begin
			shadow[wb.rd] <= wb.data;
		end
	end

	assign rs1Field = ifid.instr[19:15];
	assign rs2Field = ifid.instr[24:20];
	assign wbLive = wb.writeEnable && wb.rd != '0;
	// Same-cycle write is visible to the read
	assign expRd1 = (rs1Field == '0) ? '0 : ((wbLive && wb.rd == rs1Field) ? wb.data
		: shadow[rs1Field]);
	assign expRd2 = (rs2Field == '0) ? '0 : ((wbLive && wb.rd == rs2Field) ? wb.data
		: shadow[rs2Field]);
	assign expImm = refImm(ifid.instr);
	assign expCtrl = refCtrl(ifid.instr);
	assign expRedir = refRedir(ifid.instr, ifid.pc, expImm, fwd.srcA, fwd.srcB);
	assign expXfer = ifid.instr[6:0] == OPC_BRANCH || ifid.instr[6:0] == OPC_JAL
		|| ifid.instr[6:0] == OPC_JALR;

	// Checks, sampled between drives
	immOk: assert property (@(negedge clk) disable iff (reset) idex.immediate == expImm)
		else begin
			errors++;
			$display("FAIL %0t: immediate %h, expected %h, instr %h", $time,
				idex.immediate, expImm, ifid.instr);
		end
	ctrlOk: assert property (@(negedge clk) disable iff (reset) idex.ctrl == expCtrl)
		else begin
			errors++;
			$display("FAIL %0t: control %h, expected %h, instr %h", $time,
				idex.ctrl, expCtrl, ifid.instr);
		end
	rd1Ok: assert property (@(negedge clk) disable iff (reset) idex.regData1 == expRd1)
		else begin
			errors++;
			$display("FAIL %0t: regData1 %h, expected %h, rs1 %0d", $time,
				idex.regData1, expRd1, rs1Field);
		end
	rd2Ok: assert property (@(negedge clk) disable iff (reset) idex.regData2 == expRd2)
		else begin
			errors++;
			$display("FAIL %0t: regData2 %h, expected %h, rs2 %0d", $time,
				idex.regData2, expRd2, rs2Field);
		end
	takeOk: assert property (@(negedge clk) disable iff (reset) redir.take == expRedir.take)
		else begin
			errors++;
			$display("FAIL %0t: take %b, expected %b, instr %h", $time,
				redir.take, expRedir.take, ifid.instr);
		end
	// Target only defined for control transfers
	targetOk: assert property (@(negedge clk) disable iff (reset)
		expXfer |-> redir.target == expRedir.target)
		else begin
			errors++;
			$display("FAIL %0t: target %h, expected %h, instr %h", $time,
				redir.target, expRedir.target, ifid.instr);
		end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the run passed %0d cycles without finishing", cycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	// Stimulus helpers

	task automatic applyInputs(input logic [31:0] instr, input logic [31:0] pc,
		input logic [31:0] a, input logic [31:0] b, input logic we,
		input logic [4:0] rd, input logic [31:0] data);
		@(posedge clk);
		#1;
		ifid.instr = instr;
		ifid.pc = pc;
		ifid.pcPlus4 = pc + 32'd4;
		fwd.srcA = a;
		fwd.srcB = b;
		wb.writeEnable = we;
		wb.rd = rd;
		wb.data = data;
		vectors++;
	endtask

	function automatic logic [31:0] randomPc();
		logic [31:0] pc;
		pc = $urandom;
		pc[1:0] = 2'b00;
		return pc;
	endfunction

	// Random fields under a fixed opcode
	function automatic logic [31:0] randomWith(input logic [6:0] opc);
		logic [31:0] word;
		word = $urandom;
		word[6:0] = opc;
		return word;
	endfunction

	function automatic logic [31:0] rType(input logic [4:0] rs1, input logic [4:0] rs2);
		return {7'b0000000, rs2, rs1, 3'b000, 5'd1, OPC_OP};
	endfunction

	function automatic logic isKnown(input logic [6:0] op);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 9; i++) begin
			if (knownOps[i] == op) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	task automatic decodeOnly(input logic [31:0] instr);
		applyInputs(instr, randomPc(), $urandom, $urandom, 1'b0, 5'd0, 32'd0);
	endtask

	task automatic writeBack(input logic [31:0] instr, input logic [4:0] rd,
		input logic [31:0] data);
		applyInputs(instr, randomPc(), $urandom, $urandom, 1'b1, rd, data);
	endtask

	// Lets the last vector's checks settle, then reports
	task automatic reportTest(input string name, input int base);
		@(negedge clk);
		#0.5;
		$display("Test %s finished, %0d errors", name, errors - base);
	endtask

	initial begin
		logic [31:0] word;
		logic [31:0] value;
		logic [4:0]  rd;
		logic [6:0]  op;
		int          base;
		seedInit = $urandom(9024);
		errors = 0;
		vectors = 0;
		reset = 1'b1;
		ifid = '0;
		wb = '0;
		fwd = '0;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;

		// Every register zero, x0 ignores writes
		base = errors;
		for (int r = 0; r < `RV_REGS; r++) begin
			decodeOnly(rType(5'(r), 5'(`RV_REGS - 1 - r)));
		end
		for (int k = 0; k < x0Writes; k++) begin
			writeBack(rType(5'd0, 5'd0), 5'd0, $urandom);
			decodeOnly(rType(5'd0, 5'd0));
		end
		reportTest("reset and x0", base);

		// Write with bypass read, then read stored value
		base = errors;
		for (int k = 0; k < regWrites; k++) begin
			rd = 5'($urandom_range(31, 1));
			value = $urandom;
			writeBack(rType(rd, 5'($urandom)), rd, value);
			decodeOnly(rType(5'($urandom), rd));
		end
		reportTest("register writes and bypass", base);

		base = errors;
		for (int f = 0; f < 6; f++) begin
			for (int k = 0; k < immPerFmt; k++) begin
				word = randomWith(immOps[f]);
				// Both signs for each format
				word[31] = k[0];
				decodeOnly(word);
			end
		end
		reportTest("immediates", base);

		base = errors;
		for (int o = 0; o < 9; o++) begin
			for (int k = 0; k < ctrlPerOp; k++) begin
				// Sweep funct3 with bit 30 low then high
				word = randomWith(knownOps[o]);
				word[14:12] = 3'(k);
				word[30] = k[3];
				decodeOnly(word);
			end
		end
		for (int k = 0; k < unknownOps; k++) begin
			do begin
				op = 7'($urandom);
			end while (isKnown(op));
			decodeOnly(randomWith(op));
		end
		// FENCE and SYSTEM
		decodeOnly(randomWith(7'b0001111));
		decodeOnly(randomWith(7'b1110011));
		reportTest("control fields", base);

		base = errors;
		for (int f3 = 0; f3 < 8; f3++) begin
			if (f3 != 2 && f3 != 3) begin
				word = randomWith(OPC_BRANCH);
				word[14:12] = 3'(f3);
				value = $urandom;
				applyInputs(word, randomPc(), value, value, 1'b0, 5'd0, 32'd0);
				// Around the sign boundary
				applyInputs(word, randomPc(), 32'h7fffffff, 32'h80000000, 1'b0, 5'd0, 32'd0);
				applyInputs(word, randomPc(), 32'h80000000, 32'h7fffffff, 1'b0, 5'd0, 32'd0);
				applyInputs(word, randomPc(), 32'h00000000, 32'hffffffff, 1'b0, 5'd0, 32'd0);
				for (int k = 0; k < brRandom; k++) begin
					word = randomWith(OPC_BRANCH);
					word[14:12] = 3'(f3);
					applyInputs(word, randomPc(), $urandom, $urandom, 1'b0, 5'd0, 32'd0);
				end
			end
		end
		reportTest("branches", base);

		base = errors;
		for (int k = 0; k < jumpsPerKind; k++) begin
			decodeOnly(randomWith(OPC_JAL));
		end
		for (int k = 0; k < jumpsPerKind; k++) begin
			decodeOnly(randomWith(OPC_JALR));
		end
		reportTest("jumps", base);

		$display("Summary: 6 tests, %0d vectors, %0d errors", vectors, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
